// File: hdl/egrs_buffer.sv
module egrs_buffer (
   input  logic                                clk,
   input  logic                                we_i,
   input  logic [vdm_csr_pkg::BUF_ADDR_W-1:0]  waddr_i,
   input  logic [31:0]                         wdata_i,
   input  logic [vdm_csr_pkg::BUF_ADDR_W-1:0]  raddr_i,
   output logic [31:0]                         rdata_o
);
   logic [31:0] mem [2**vdm_csr_pkg::BUF_ADDR_W];

   always_ff @(posedge clk) begin
      if (we_i) begin
         mem[waddr_i] <= wdata_i;
      end
      rdata_o <= mem[raddr_i];    // Data one cycle after address
   end

endmodule

// File: hdl/egrs_csr.sv
module egrs_csr (
   input  logic                                clk,
   input  logic                                reset,
   input  logic [vdm_csr_pkg::CSR_ADDR_W-1:0]  slv_addr_i,
   input  logic                                slv_write_i,
   input  logic                                slv_read_i,
   input  logic [31:0]                         slv_wrdata_i,
   input  logic [7:0]                          src_eid_i,
   input  vdm_tlp_pkg::egrs_state_e            state_i,
   output logic [31:0]                         slv_rddata_o,
   output logic                                slv_rddvld_o,
   output logic                                slv_waitreq_o,
   output logic                                msg_rdy_o,
   output logic [vdm_csr_pkg::MSG_LEN_W-1:0]   msg_len_o,
   output logic [1:0]                          pad_len_o,
   output logic [15:0]                         tid_o,
   output logic [7:0]                          deid_o,
   output logic [3:0]                          tag_o,
   output logic [7:0]                          seid_o,
   output logic [2:0]                          route_o,
   output logic                                buf_we_o,
   output logic [vdm_csr_pkg::BUF_ADDR_W-1:0]  buf_waddr_o,
   output logic [31:0]                         buf_wdata_o
);
   logic idle;       // Message contents may change
   logic ctrl_wr;
   logic hdr_wr;
   logic by_id;

   assign idle    = (state_i == vdm_tlp_pkg::ST_IDLE) && !msg_rdy_o;
   assign ctrl_wr = idle && slv_write_i && (slv_addr_i == vdm_csr_pkg::CTRL_ADDR);
   assign hdr_wr  = idle && slv_write_i && (slv_addr_i == vdm_csr_pkg::HDR_ADDR);
   assign by_id   = slv_wrdata_i[vdm_csr_pkg::HDR_ROUTE_ID_BIT];

   always_ff @(posedge clk, posedge reset) begin
      if (reset) begin
         msg_rdy_o <= 1'b0;
         msg_len_o <= '0;
         pad_len_o <= '0;
         tid_o     <= '0;
         deid_o    <= '0;
         tag_o     <= '0;
         seid_o    <= '0;
         route_o   <= vdm_tlp_pkg::ROUTE_RC;
      end else begin
         msg_rdy_o <= ctrl_wr && slv_wrdata_i[vdm_csr_pkg::CTRL_RDY_BIT];   // One cycle
         if (ctrl_wr) begin
            msg_len_o <= slv_wrdata_i[vdm_csr_pkg::CTRL_LEN_LSB +: vdm_csr_pkg::MSG_LEN_W];
            pad_len_o <= slv_wrdata_i[vdm_csr_pkg::CTRL_PAD_LSB +: 2];
         end
         // Routing and null EID resolved here
         if (hdr_wr) begin
            tid_o   <= by_id ? slv_wrdata_i[vdm_csr_pkg::HDR_TID_LSB +: 16] : 16'd0;
            deid_o  <= slv_wrdata_i[vdm_csr_pkg::HDR_DEID_LSB +: 8];
            tag_o   <= slv_wrdata_i[vdm_csr_pkg::HDR_TAG_LSB +: 4];
            seid_o  <= slv_wrdata_i[vdm_csr_pkg::HDR_NULL_EID_BIT] ? 8'd0 : src_eid_i;
            route_o <= by_id ? vdm_tlp_pkg::ROUTE_ID : vdm_tlp_pkg::ROUTE_RC;
         end
      end
   end

   // Fixed latency status read
   always_ff @(posedge clk, posedge reset) begin
      if (reset) begin
         slv_waitreq_o <= 1'b1;
         slv_rddvld_o  <= 1'b0;
         slv_rddata_o  <= '0;
      end else begin
         slv_waitreq_o <= 1'b0;
         slv_rddvld_o  <= slv_read_i;
         slv_rddata_o  <= 32'(!idle) << vdm_csr_pkg::CTRL_BUSY_BIT;
      end
   end

   assign buf_we_o    = idle && slv_write_i && slv_addr_i[vdm_csr_pkg::BUF_SEL_BIT];
   assign buf_waddr_o = slv_addr_i[vdm_csr_pkg::BUF_ADDR_W-1:0];
   assign buf_wdata_o = slv_wrdata_i;

   // FSM must still be idle when the start pulse arrives
   a_rdy_in_idle : assert property (@(posedge clk) disable iff (reset)
      msg_rdy_o |-> state_i == vdm_tlp_pkg::ST_IDLE);

endmodule

// File: hdl/egrs_frag_counter.sv
module egrs_frag_counter (
   input  logic                                 clk,
   input  logic                                 reset,
   input  vdm_tlp_pkg::egrs_state_e             state_i,
   input  logic [vdm_csr_pkg::MSG_LEN_W-1:0]    msg_len_i,
   input  logic                                 word_read_i,
   output logic [vdm_tlp_pkg::FRAG_LEN_W-1:0]   frag_len_o,
   output logic                                 last_frag_o,
   output logic                                 pld_done_o,
   output logic                                 som_o,
   output logic                                 eom_o,
   output logic [1:0]                           seq_o,
   output logic                                 gap_done_o
);
   logic [vdm_csr_pkg::MSG_LEN_W-1:0]          pend_len;   // DWORDs not yet sent
   logic [vdm_tlp_pkg::FRAG_LEN_W-1:0]         pld_cnt;    // DWORDs left to fetch
   logic                                       rem_one;
   logic [$clog2(vdm_tlp_pkg::GAP_CYCLES)-1:0] gap_cnt;
   logic                                       in_gap;
   logic                                       gap_start;
   logic                                       eop_q;

   assign last_frag_o = pend_len <= vdm_csr_pkg::MSG_LEN_W'(vdm_tlp_pkg::MTU_DW);
   assign frag_len_o  = last_frag_o ? pend_len[vdm_tlp_pkg::FRAG_LEN_W-1:0]
                                    : vdm_tlp_pkg::FRAG_LEN_W'(vdm_tlp_pkg::MTU_DW);
   assign pld_done_o  = pld_cnt == '0;
   assign rem_one     = pld_cnt == vdm_tlp_pkg::FRAG_LEN_W'(1);   // Odd final DWORD
   assign in_gap      = state_i == vdm_tlp_pkg::ST_GAP;
   assign gap_start   = in_gap && gap_cnt == '0;
   assign gap_done_o  = in_gap && gap_cnt == ($bits(gap_cnt))'(vdm_tlp_pkg::GAP_CYCLES - 1);

   always_ff @(posedge clk, posedge reset) begin
      if (reset) begin
         pend_len <= '0;
         pld_cnt  <= '0;
         gap_cnt  <= '0;
         som_o    <= 1'b0;
         eom_o    <= 1'b0;
         seq_o    <= '0;
         eop_q    <= 1'b0;
      end else begin
         eop_q <= state_i == vdm_tlp_pkg::ST_EOP;

         if (state_i == vdm_tlp_pkg::ST_IDLE) begin
            pend_len <= msg_len_i;
         end else if (gap_start) begin
            pend_len <= pend_len - vdm_csr_pkg::MSG_LEN_W'(vdm_tlp_pkg::MTU_DW);
         end

         // Two DWORDs per payload word
         if (state_i != vdm_tlp_pkg::ST_PLOAD) begin
            pld_cnt <= frag_len_o;
         end else if (word_read_i) begin
            pld_cnt <= rem_one ? '0 : pld_cnt - vdm_tlp_pkg::FRAG_LEN_W'(2);
         end

         if (!in_gap || gap_done_o) begin
            gap_cnt <= '0;
         end else begin
            gap_cnt <= gap_cnt + 1'b1;
         end

         if (state_i == vdm_tlp_pkg::ST_IDLE) begin
            som_o <= 1'b1;
         end else if (in_gap) begin
            som_o <= 1'b0;            // Only the first fragment
         end
         if (state_i == vdm_tlp_pkg::ST_SOP) begin
            eom_o <= last_frag_o;
         end
         if (eop_q && state_i != vdm_tlp_pkg::ST_EOP) begin
            seq_o <= seq_o + 1'b1;    // Wraps across messages
         end
      end
   end

   // Master never fetches more words than the fragment holds
   a_no_underflow : assert property (@(posedge clk) disable iff (reset)
      word_read_i |-> !pld_done_o);

endmodule

// File: hdl/egrs_fsm.sv
module egrs_fsm (
   input  logic                      clk,
   input  logic                      reset,
   input  logic                      msg_rdy_i,
   input  logic                      wr_acc_i,
   input  logic                      pld_done_i,
   input  logic                      last_frag_i,
   input  logic                      gap_done_i,
   output vdm_tlp_pkg::egrs_state_e  state_o
);
   vdm_tlp_pkg::egrs_state_e next_st;

   always_ff @(posedge clk, posedge reset) begin
      if (reset) begin
         state_o <= vdm_tlp_pkg::ST_IDLE;
      end else begin
         state_o <= next_st;
      end
   end

   //----------------------------------------------------------
   // Next state, each write phase ends on acceptance
   //----------------------------------------------------------
   always_comb begin
      next_st = state_o;
      case (state_o)
         vdm_tlp_pkg::ST_IDLE:
            if (msg_rdy_i) next_st = vdm_tlp_pkg::ST_SOP;
         vdm_tlp_pkg::ST_SOP:
            if (wr_acc_i) next_st = vdm_tlp_pkg::ST_HDR1;
         vdm_tlp_pkg::ST_HDR1:
            if (wr_acc_i) next_st = vdm_tlp_pkg::ST_HDR2;
         vdm_tlp_pkg::ST_HDR2:
            if (wr_acc_i) next_st = vdm_tlp_pkg::ST_PLOAD;
         vdm_tlp_pkg::ST_PLOAD:
            if (wr_acc_i && pld_done_i) next_st = vdm_tlp_pkg::ST_EOP;   // Last word out
         vdm_tlp_pkg::ST_EOP:
            if (wr_acc_i) begin
               next_st = last_frag_i ? vdm_tlp_pkg::ST_IDLE : vdm_tlp_pkg::ST_GAP;
            end
         vdm_tlp_pkg::ST_GAP:
            if (gap_done_i) next_st = vdm_tlp_pkg::ST_SOP;
         default:
            next_st = vdm_tlp_pkg::ST_IDLE;
      endcase
   end

   a_legal_state : assert property (@(posedge clk) disable iff (reset)
      !$isunknown(state_o) && state_o inside {vdm_tlp_pkg::ST_IDLE, vdm_tlp_pkg::ST_SOP,
         vdm_tlp_pkg::ST_HDR1, vdm_tlp_pkg::ST_HDR2, vdm_tlp_pkg::ST_PLOAD,
         vdm_tlp_pkg::ST_EOP, vdm_tlp_pkg::ST_GAP});

endmodule

// File: hdl/egrs_tlp_mstr.sv
module egrs_tlp_mstr (
   input  logic                                  clk,
   input  logic                                  reset,
   input  vdm_tlp_pkg::egrs_state_e              state_i,
   input  logic [vdm_tlp_pkg::MSTR_ADDR_W-1:0]   afu_base_i,
   input  logic                                  mstr_waitreq_i,
   input  logic [31:0]                           buf_rdata_i,
   input  logic [vdm_tlp_pkg::FRAG_LEN_W-1:0]    frag_len_i,
   input  logic                                  som_i,
   input  logic                                  eom_i,
   input  logic [1:0]                            seq_i,
   input  logic [1:0]                            pad_len_i,
   input  logic [15:0]                           tid_i,
   input  logic [7:0]                            deid_i,
   input  logic [3:0]                            tag_i,
   input  logic [7:0]                            seid_i,
   input  logic [2:0]                            route_i,
   input  logic                                  last_frag_i,
   output logic [vdm_csr_pkg::BUF_ADDR_W-1:0]    buf_raddr_o,
   output logic                                  word_read_o,
   output logic                                  wr_acc_o,
   output logic [vdm_tlp_pkg::MSTR_ADDR_W-1:0]   mstr_addr_o,
   output logic                                  mstr_write_o,
   output logic [63:0]                           mstr_wrdata_o,
   output logic [7:0]                            mstr_byteen_o
);
   logic                                 pload;
   logic                                 ctl_st;     // Marker or header phase
   logic                                 load;
   logic                                 issue_lo;
   logic                                 issue_hi;
   logic                                 ph1;        // Low DWORD on read data
   logic                                 hi_vld;
   logic [31:0]                          lo_q;
   logic [vdm_tlp_pkg::FRAG_LEN_W-1:0]   rd_left;    // DWORDs still to request
   logic [9:0]                           tlp_len;
   logic [3:0]                           ofs;
   logic [63:0]                          hdr1;
   logic [63:0]                          hdr2;

   assign pload    = state_i == vdm_tlp_pkg::ST_PLOAD;
   assign ctl_st   = state_i inside {vdm_tlp_pkg::ST_SOP, vdm_tlp_pkg::ST_HDR1,
                                     vdm_tlp_pkg::ST_HDR2, vdm_tlp_pkg::ST_EOP};
   assign wr_acc_o = mstr_write_o && !mstr_waitreq_i;
   assign load     = (ctl_st && !mstr_write_o) || word_read_o;

   // A new pair starts only when the write slot is free
   assign issue_lo = pload && rd_left != '0 && !ph1 && !word_read_o &&
                     (!mstr_write_o || wr_acc_o);
   assign issue_hi = ph1 && rd_left != '0;

   //----------------------------------------------------------
   // TLP header words, byte 0 in the low bits
   //----------------------------------------------------------
   assign tlp_len = 10'(frag_len_i);
   assign hdr1 = {vdm_tlp_pkg::VDM_MSG_CODE,
                  2'd0, last_frag_i ? pad_len_i : 2'd0, 4'd0,
                  16'd0,
                  tlp_len[7:0],
                  6'd0, tlp_len[9:8],      // No snoop attribute clear
                  8'd0,
                  vdm_tlp_pkg::TLP_FMT_TYPE, route_i};
   assign hdr2 = {som_i, eom_i, seq_i, tag_i,
                  seid_i,
                  deid_i,
                  4'h0, vdm_tlp_pkg::MCTP_HDR_VER,
                  vdm_tlp_pkg::VDM_VENDOR_ID[7:0],
                  vdm_tlp_pkg::VDM_VENDOR_ID[15:8],
                  tid_i[7:0],
                  tid_i[15:8]};          // Target ID byte swapped
   assign ofs = (state_i == vdm_tlp_pkg::ST_SOP || state_i == vdm_tlp_pkg::ST_EOP) ?
                vdm_tlp_pkg::MARK_OFS : vdm_tlp_pkg::DATA_OFS;

   always_ff @(posedge clk, posedge reset) begin
      if (reset) begin
         mstr_write_o <= 1'b0;
         ph1          <= 1'b0;
         word_read_o  <= 1'b0;
         hi_vld       <= 1'b0;
         buf_raddr_o  <= '0;
         rd_left      <= '0;
      end else begin
         if (load) begin
            mstr_write_o <= 1'b1;
         end else if (wr_acc_o) begin
            mstr_write_o <= 1'b0;
         end
         ph1         <= issue_lo;
         word_read_o <= ph1;           // High DWORD or none on read data
         hi_vld      <= issue_hi;
         if (state_i == vdm_tlp_pkg::ST_IDLE) begin
            buf_raddr_o <= '0;
         end else if (issue_lo || issue_hi) begin
            buf_raddr_o <= buf_raddr_o + 1'b1;   // Runs on across fragments
         end
         if (!pload) begin
            rd_left <= frag_len_i;
         end else if (issue_lo || issue_hi) begin
            rd_left <= rd_left - 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (ph1) begin
         lo_q <= buf_rdata_i;
      end
      if (load) begin
         mstr_addr_o   <= {afu_base_i[vdm_tlp_pkg::MSTR_ADDR_W-1:4], ofs};
         mstr_byteen_o <= (word_read_o && !hi_vld) ? 8'h0F : 8'hFF;
         case (state_i)
            vdm_tlp_pkg::ST_SOP:  mstr_wrdata_o <= 64'd1;
            vdm_tlp_pkg::ST_HDR1: mstr_wrdata_o <= hdr1;
            vdm_tlp_pkg::ST_HDR2: mstr_wrdata_o <= hdr2;
            vdm_tlp_pkg::ST_EOP:  mstr_wrdata_o <= 64'd2;
            default:              mstr_wrdata_o <= {hi_vld ? buf_rdata_i : 32'd0, lo_q};
         endcase
      end
   end

   a_hold_on_wait : assert property (@(posedge clk) disable iff (reset)
      mstr_write_o && mstr_waitreq_i |=>
         mstr_write_o && $stable(mstr_addr_o) && $stable(mstr_wrdata_o));

endmodule

// File: hdl/mctp_vdm_egress.sv
module mctp_vdm_egress (
   input  logic                                  clk,
   input  logic                                  reset,
   input  logic [7:0]                            src_eid_i,
   input  logic [vdm_tlp_pkg::MSTR_ADDR_W-1:0]   afu_base_i,
   input  logic [vdm_csr_pkg::CSR_ADDR_W-1:0]    slv_addr_i,
   input  logic                                  slv_write_i,
   input  logic                                  slv_read_i,
   input  logic [31:0]                           slv_wrdata_i,
   output logic [31:0]                           slv_rddata_o,
   output logic                                  slv_rddvld_o,
   output logic                                  slv_waitreq_o,
   output logic [vdm_tlp_pkg::MSTR_ADDR_W-1:0]   mstr_addr_o,
   output logic                                  mstr_write_o,
   output logic [63:0]                           mstr_wrdata_o,
   output logic [7:0]                            mstr_byteen_o,
   input  logic                                  mstr_waitreq_i
);
   vdm_tlp_pkg::egrs_state_e             state;
   logic                                 msg_rdy;
   logic [vdm_csr_pkg::MSG_LEN_W-1:0]    msg_len;
   logic [1:0]                           pad_len;
   logic [15:0]                          tid;
   logic [7:0]                           deid;
   logic [3:0]                           tag;
   logic [7:0]                           seid;
   logic [2:0]                           route;
   logic                                 buf_we;
   logic [vdm_csr_pkg::BUF_ADDR_W-1:0]   buf_waddr;
   logic [31:0]                          buf_wdata;
   logic [vdm_csr_pkg::BUF_ADDR_W-1:0]   buf_raddr;
   logic [31:0]                          buf_rdata;
   logic                                 wr_acc;
   logic                                 word_read;
   logic                                 last_frag;
   logic                                 pld_done;
   logic                                 gap_done;
   logic [vdm_tlp_pkg::FRAG_LEN_W-1:0]   frag_len;
   logic                                 som;
   logic                                 eom;
   logic [1:0]                           seq;

   // Host side
   egrs_csr egrs_csr_i (
      .clk           (clk),
      .reset         (reset),
      .slv_addr_i    (slv_addr_i),
      .slv_write_i   (slv_write_i),
      .slv_read_i    (slv_read_i),
      .slv_wrdata_i  (slv_wrdata_i),
      .src_eid_i     (src_eid_i),
      .state_i       (state),
      .slv_rddata_o  (slv_rddata_o),
      .slv_rddvld_o  (slv_rddvld_o),
      .slv_waitreq_o (slv_waitreq_o),
      .msg_rdy_o     (msg_rdy),
      .msg_len_o     (msg_len),
      .pad_len_o     (pad_len),
      .tid_o         (tid),
      .deid_o        (deid),
      .tag_o         (tag),
      .seid_o        (seid),
      .route_o       (route),
      .buf_we_o      (buf_we),
      .buf_waddr_o   (buf_waddr),
      .buf_wdata_o   (buf_wdata)
   );

   egrs_buffer egrs_buffer_i (
      .clk     (clk),
      .we_i    (buf_we),
      .waddr_i (buf_waddr),
      .wdata_i (buf_wdata),
      .raddr_i (buf_raddr),
      .rdata_o (buf_rdata)
   );

   //----------------------------------------------------------
   // Fragment sequencing
   //----------------------------------------------------------
   egrs_fsm egrs_fsm_i (
      .clk         (clk),
      .reset       (reset),
      .msg_rdy_i   (msg_rdy),
      .wr_acc_i    (wr_acc),
      .pld_done_i  (pld_done),
      .last_frag_i (last_frag),
      .gap_done_i  (gap_done),
      .state_o     (state)
   );

   egrs_frag_counter egrs_frag_counter_i (
      .clk         (clk),
      .reset       (reset),
      .state_i     (state),
      .msg_len_i   (msg_len),
      .word_read_i (word_read),
      .frag_len_o  (frag_len),
      .last_frag_o (last_frag),
      .pld_done_o  (pld_done),
      .som_o       (som),
      .eom_o       (eom),
      .seq_o       (seq),
      .gap_done_o  (gap_done)
   );

   // Master side
   egrs_tlp_mstr egrs_tlp_mstr_i (
      .clk            (clk),
      .reset          (reset),
      .state_i        (state),
      .afu_base_i     (afu_base_i),
      .mstr_waitreq_i (mstr_waitreq_i),
      .buf_rdata_i    (buf_rdata),
      .frag_len_i     (frag_len),
      .som_i          (som),
      .eom_i          (eom),
      .seq_i          (seq),
      .pad_len_i      (pad_len),
      .tid_i          (tid),
      .deid_i         (deid),
      .tag_i          (tag),
      .seid_i         (seid),
      .route_i        (route),
      .last_frag_i    (last_frag),
      .buf_raddr_o    (buf_raddr),
      .word_read_o    (word_read),
      .wr_acc_o       (wr_acc),
      .mstr_addr_o    (mstr_addr_o),
      .mstr_write_o   (mstr_write_o),
      .mstr_wrdata_o  (mstr_wrdata_o),
      .mstr_byteen_o  (mstr_byteen_o)
   );

endmodule

// File: hdl/vdm_csr_pkg.sv
package vdm_csr_pkg;

   //----------------------------------------------------------
   // Host port address map
   //----------------------------------------------------------
   localparam int             CSR_ADDR_W  = 9;
   localparam logic [8:0]     CTRL_ADDR   = 9'd0;   // Control and status
   localparam logic [8:0]     HDR_ADDR    = 9'd1;   // Packet header
   localparam int             BUF_SEL_BIT = 8;      // Set for packet buffer
   localparam int             BUF_ADDR_W  = 8;

   // Control register fields
   localparam int             CTRL_RDY_BIT  = 0;    // Message ready, write only
   localparam int             CTRL_BUSY_BIT = 1;    // Engine busy, read only
   localparam int             CTRL_PAD_LSB  = 4;    // 2 bits
   localparam int             CTRL_LEN_LSB  = 6;    // Length in DWORDs

   // Header register fields
   localparam int             HDR_TID_LSB      = 0;    // PCIe target ID, 16 bits
   localparam int             HDR_DEID_LSB     = 16;   // Destination EID
   localparam int             HDR_TAG_LSB      = 24;   // TO bit over 3-bit tag
   localparam int             HDR_NULL_EID_BIT = 28;
   localparam int             HDR_ROUTE_ID_BIT = 29;   // Else route to RC

   localparam int             MSG_LEN_W = 9;

endpackage

// File: hdl/vdm_tlp_pkg.sv
package vdm_tlp_pkg;

   // Fragmentation
   localparam int          MTU_DW     = 16;     // Baseline MTU in DWORDs
   localparam int          FRAG_LEN_W = 5;
   localparam int          GAP_CYCLES = 64;     // Idle cycles between fragments

   //----------------------------------------------------------
   // PCIe VDM and MCTP header constants
   //----------------------------------------------------------
   localparam logic [3:0]  MCTP_HDR_VER  = 4'h1;
   localparam logic [15:0] VDM_VENDOR_ID = 16'h1AB4;
   localparam logic [7:0]  VDM_MSG_CODE  = 8'h7F;      // Vendor defined type 1
   localparam logic [4:0]  TLP_FMT_TYPE  = 5'h0E;      // Message with data, 4DW header
   localparam logic [2:0]  ROUTE_RC      = 3'd0;
   localparam logic [2:0]  ROUTE_ID      = 3'd2;

   // Master port
   localparam int          MSTR_ADDR_W = 21;
   localparam logic [3:0]  MARK_OFS    = 4'h0;     // SOP and EOP markers
   localparam logic [3:0]  DATA_OFS    = 4'h8;     // Headers and payload

   //----------------------------------------------------------
   // Fragment transmit states
   //----------------------------------------------------------
   typedef enum logic [2:0] {
      ST_IDLE  = 3'd0,
      ST_SOP   = 3'd1,
      ST_HDR1  = 3'd2,
      ST_HDR2  = 3'd3,
      ST_PLOAD = 3'd4,
      ST_EOP   = 3'd5,
      ST_GAP   = 3'd6
   } egrs_state_e;

endpackage

// File: run.sh
#!/bin/sh
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_mctp_vdm_egress \
   -f tb.f -o tb_sim > sim.log 2>&1 &&
   ./obj_dir/tb_sim >> sim.log 2>&1
grep -q ">>> FAIL" sim.log && { echo "Simulation failed, see sim.log"; exit 1; }
grep -q ">>> PASS" sim.log || { echo "Simulation did not finish, see sim.log"; exit 1; }
echo "Simulation passed"

// File: tb.f
+incdir+test
hdl/vdm_csr_pkg.sv
hdl/vdm_tlp_pkg.sv
hdl/egrs_csr.sv
hdl/egrs_buffer.sv
hdl/egrs_fsm.sv
hdl/egrs_frag_counter.sv
hdl/egrs_tlp_mstr.sv
hdl/mctp_vdm_egress.sv
test/tb_mctp_vdm_egress.sv

// File: test/egress_model.svh
`ifndef EGRESS_MODEL_SVH
`define EGRESS_MODEL_SVH

// One expected master write
typedef struct packed {
   logic [20:0] addr;
   logic [63:0] data;
   logic [7:0]  byteen;
} mstr_wr_t;

mstr_wr_t   exp_q[$];     // Writes still to be seen, oldest first
logic [1:0] model_seq;    // MCTP sequence, runs on across messages

function automatic void push_write(input logic [20:0] addr, input logic [63:0] data,
                                   input logic [7:0] byteen);
   mstr_wr_t w;
   w.addr   = addr;
   w.data   = data;
   w.byteen = byteen;
   exp_q.push_back(w);
endfunction

// Byte 0 goes out in the low bits of the bus word
function automatic logic [63:0] bytes_to_word(input logic [7:0] b [8]);
   logic [63:0] w;
   w = '0;
   for (int k = 0; k < 8; k++) begin
      w[8*k +: 8] = b[k];
   end
   return w;
endfunction

//------------------------------------------------------------
// Full write sequence of one message held in msg_dw
//------------------------------------------------------------
function automatic void predict_message(input int len, input logic [1:0] pad,
                                        input logic [31:0] hdr_reg, input logic [7:0] src_eid,
                                        input logic [20:0] base);
   int          sent;
   int          flen;
   logic        first;
   logic        last;
   logic        by_id;
   logic [15:0] tid;
   logic [7:0]  seid;
   logic [20:0] mark_addr;
   logic [20:0] data_addr;
   logic [7:0]  hb [8];

   by_id     = hdr_reg[vdm_csr_pkg::HDR_ROUTE_ID_BIT];
   tid       = by_id ? hdr_reg[vdm_csr_pkg::HDR_TID_LSB +: 16] : 16'd0;
   seid      = hdr_reg[vdm_csr_pkg::HDR_NULL_EID_BIT] ? 8'd0 : src_eid;
   mark_addr = {base[20:4], vdm_tlp_pkg::MARK_OFS};
   data_addr = {base[20:4], vdm_tlp_pkg::DATA_OFS};
   sent      = 0;
   while (sent < len) begin
      flen  = (len - sent > vdm_tlp_pkg::MTU_DW) ? vdm_tlp_pkg::MTU_DW : len - sent;
      first = sent == 0;
      last  = sent + flen == len;
      push_write(mark_addr, 64'd1, 8'hFF);    // SOP
      // PCIe DW0 and requester DW
      hb[0] = {vdm_tlp_pkg::TLP_FMT_TYPE,
               (by_id ? vdm_tlp_pkg::ROUTE_ID : vdm_tlp_pkg::ROUTE_RC)};
      hb[1] = 8'd0;
      hb[2] = 8'(flen >> 8);
      hb[3] = 8'(flen);
      hb[4] = 8'd0;
      hb[5] = 8'd0;
      hb[6] = last ? {2'b00, pad, 4'b0000} : 8'd0;
      hb[7] = vdm_tlp_pkg::VDM_MSG_CODE;
      push_write(data_addr, bytes_to_word(hb), 8'hFF);
      // Target ID, vendor and MCTP transport header
      hb[0] = tid[15:8];
      hb[1] = tid[7:0];
      hb[2] = vdm_tlp_pkg::VDM_VENDOR_ID[15:8];
      hb[3] = vdm_tlp_pkg::VDM_VENDOR_ID[7:0];
      hb[4] = {4'h0, vdm_tlp_pkg::MCTP_HDR_VER};
      hb[5] = hdr_reg[vdm_csr_pkg::HDR_DEID_LSB +: 8];
      hb[6] = seid;
      hb[7] = {first, last, model_seq, hdr_reg[vdm_csr_pkg::HDR_TAG_LSB +: 4]};
      push_write(data_addr, bytes_to_word(hb), 8'hFF);
      for (int i = 0; i < flen; i += 2) begin
         if (i + 1 < flen) begin
            push_write(data_addr, {msg_dw[sent+i+1], msg_dw[sent+i]}, 8'hFF);
         end else begin
            push_write(data_addr, {32'd0, msg_dw[sent+i]}, 8'h0F);   // Odd final DWORD
         end
      end
      push_write(mark_addr, 64'd2, 8'hFF);    // EOP
      model_seq = model_seq + 2'd1;
      sent      = sent + flen;
   end
endfunction

`endif

// File: test/tb_mctp_vdm_egress.sv
module tb_mctp_vdm_egress;

   localparam int NUM_MSGS  = 30;
   localparam int DONE_WAIT = 1000;   // Status polls per message

   logic                                  clk;
   logic                                  reset;
   logic [7:0]                            src_eid_i;
   logic [vdm_tlp_pkg::MSTR_ADDR_W-1:0]   afu_base_i;
   logic [vdm_csr_pkg::CSR_ADDR_W-1:0]    slv_addr_i;
   logic                                  slv_write_i;
   logic                                  slv_read_i;
   logic [31:0]                           slv_wrdata_i;
   logic [31:0]                           slv_rddata_o;
   logic                                  slv_rddvld_o;
   logic                                  slv_waitreq_o;
   logic [vdm_tlp_pkg::MSTR_ADDR_W-1:0]   mstr_addr_o;
   logic                                  mstr_write_o;
   logic [63:0]                           mstr_wrdata_o;
   logic [7:0]                            mstr_byteen_o;
   logic                                  mstr_waitreq_i;
   logic                                  bp_en;       // Random back-pressure on
   logic [31:0]                           msg_dw [256];

   `include "egress_model.svh"

   mctp_vdm_egress mctp_vdm_egress_i (.*);

   always #2 clk = ~clk;

   task automatic report_failure(input string why);
      $display("%s", why);
      $display(">>> FAIL");
      $fatal(1, "Simulation stopped");
   endtask

   task automatic check_equal(input string what, input logic [63:0] got,
                              input logic [63:0] exp);
      if (got !== exp) begin
         $display("ERROR at %0t: %s is %0h, expected %0h", $time, what, got, exp);
         report_failure("Stopped at the first mismatch");
      end
   endtask

   //------------------------------------------------------------
   // Host port
   //------------------------------------------------------------
   task automatic host_write(input logic [8:0] addr, input logic [31:0] data);
      @(posedge clk);
      #1;
      slv_addr_i   = addr;
      slv_wrdata_i = data;
      slv_write_i  = 1'b1;
      @(posedge clk);
      #1;
      slv_write_i  = 1'b0;
   endtask

   task automatic read_status(output logic busy);
      @(posedge clk);
      #1;
      check_equal("status data valid without a read", 64'(slv_rddvld_o), 64'd0);
      slv_addr_i = vdm_csr_pkg::CTRL_ADDR;
      slv_read_i = 1'b1;
      @(posedge clk);
      #1;
      slv_read_i = 1'b0;
      // Read data comes back one cycle after the read
      check_equal("status data valid", 64'(slv_rddvld_o), 64'd1);
      check_equal("status spare bits",
                  64'(slv_rddata_o & ~(32'd1 << vdm_csr_pkg::CTRL_BUSY_BIT)), 64'd0);
      busy = slv_rddata_o[vdm_csr_pkg::CTRL_BUSY_BIT];
   endtask

   function automatic logic [31:0] ctrl_word(input int len, input logic [1:0] pad,
                                             input logic rdy);
      return (32'(len) << vdm_csr_pkg::CTRL_LEN_LSB) |
             (32'(pad) << vdm_csr_pkg::CTRL_PAD_LSB) |
             (32'(rdy) << vdm_csr_pkg::CTRL_RDY_BIT);
   endfunction

   // Back-pressure about 30% of cycles
   always @(posedge clk) begin
      #1;
      mstr_waitreq_i = bp_en && ($urandom_range(99) < 30);
   end

   // Accepted write monitor
   always @(negedge clk) begin
      if (!reset && mstr_write_o && !mstr_waitreq_i) begin
         if (exp_q.size() == 0) begin
            report_failure("Master write seen while no write was expected");
         end else begin
            check_equal("master address", 64'(mstr_addr_o), 64'(exp_q[0].addr));
            check_equal("master data", mstr_wrdata_o, exp_q[0].data);
            check_equal("master byte enables", 64'(mstr_byteen_o), 64'(exp_q[0].byteen));
            void'(exp_q.pop_front());
         end
      end
   end

   initial begin
      int          len;
      int          t;
      logic [1:0]  pad;
      logic [31:0] hdr;
      logic        busy;

      void'($urandom(79656));
      clk            = 1'b0;
      reset          = 1'b1;
      src_eid_i      = '0;
      afu_base_i     = '0;
      slv_addr_i     = '0;
      slv_write_i    = 1'b0;
      slv_read_i     = 1'b0;
      slv_wrdata_i   = '0;
      mstr_waitreq_i = 1'b0;
      bp_en          = 1'b0;
      model_seq      = 2'd0;
      repeat (16) @(posedge clk);
      #1;
      check_equal("host waitrequest in reset", 64'(slv_waitreq_o), 64'd1);
      reset = 1'b0;
      t = 0;
      while (slv_waitreq_o && t < 10) begin
         @(posedge clk);
         #1;
         t++;
      end
      if (slv_waitreq_o) report_failure("Host waitrequest stayed high after reset");

      for (int m = 0; m < NUM_MSGS; m++) begin
         // Single fragment messages first and multi fragment after
         len        = (m < 12) ? 1 + $urandom_range(15) : 17 + $urandom_range(47);
         pad        = 2'($urandom);
         hdr        = $urandom;
         bp_en      = (m % 3) != 0;
         src_eid_i  = 8'($urandom);
         afu_base_i = 21'($urandom);
         for (int i = 0; i < len; i++) begin
            msg_dw[i] = $urandom;
            host_write({1'b1, 8'(i)}, msg_dw[i]);
         end
         host_write(vdm_csr_pkg::HDR_ADDR, hdr);
         predict_message(len, pad, hdr, src_eid_i, afu_base_i);
         host_write(vdm_csr_pkg::CTRL_ADDR, ctrl_word(len, pad, 1'b1));

         // Engine busy so all of these get dropped
         host_write({1'b1, 8'd0}, ~msg_dw[0]);
         host_write(vdm_csr_pkg::HDR_ADDR, ~hdr);
         host_write(vdm_csr_pkg::CTRL_ADDR, ctrl_word(len + 1, ~pad, 1'b1));
         read_status(busy);
         check_equal("busy during transmission", 64'(busy), 64'd1);

         t = 0;
         while (busy && t < DONE_WAIT) begin
            read_status(busy);
            t++;
         end
         if (busy) report_failure("Timed out waiting for the engine to go idle");
         check_equal("writes missing after message", 64'(exp_q.size()), 64'd0);
      end

      if (exp_q.size() == 0) begin
         $display(">>> PASS");
         $finish;
      end else begin
         report_failure("Expected master writes never appeared");
      end
   end

endmodule
